/* run_sim.sh */
#!/bin/sh
# compile and run the WQE fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module wqe_fetch_tb \
    -f vlog.f -o wqe_fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/wqe_fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0

/* source/sq_read_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module sq_read_execute
    import wqe_fetch_pkg::*;
#(
    parameter int MAX_QP   = 16,
    parameter int SQ_DEPTH = 4096
)(
    input  logic                  clk,
    input  logic                  rst_n,
    input  addr_t                 i_sq_base,
    // command from the scheduler
    input  logic                  i_cmd_valid,
    input  logic [QPID_WIDTH-1:0] i_cmd_qp,
    output logic                  o_cmd_ready,
    // AXI read address channel
    output addr_t                 o_axi_araddr,
    output logic                  o_axi_arvalid,
    input  logic                  i_axi_arready,
    // AXI read data channel
    input  logic [WQE_WIDTH-1:0]  i_axi_rdata,
    input  logic                  i_axi_rvalid,
    output logic                  o_axi_rready,
    // beat handed to the push stage
    output logic                  o_rd_valid,
    output logic [QPID_WIDTH-1:0] o_rd_qp,
    output logic [WQE_WIDTH-1:0]  o_rd_data,
    input  logic                  i_rd_ready
);

    localparam int    PI_WIDTH = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
    // queues sit back to back from i_sq_base
    localparam addr_t SQ_BYTES = addr_t'(SQ_DEPTH * WQE_BYTES);

    logic [PI_WIDTH-1:0] sq_pi [MAX_QP];
    addr_t               wqe_addr;
    logic                cmd_fire;
    logic                ar_fire;
    logic                r_fire;
    logic                rd_fire;

    // a new command waits until the single WQE in flight has drained
    assign o_cmd_ready = ~(o_axi_arvalid | o_axi_rready | o_rd_valid);

    assign cmd_fire = i_cmd_valid & o_cmd_ready;
    assign ar_fire  = o_axi_arvalid & i_axi_arready;
    assign r_fire   = o_axi_rready & i_axi_rvalid;
    assign rd_fire  = o_rd_valid & i_rd_ready;

    // base + qp * queue size + producer index * WQE size
    assign wqe_addr = i_sq_base
                    + addr_t'(i_cmd_qp) * SQ_BYTES
                    + addr_t'(sq_pi[i_cmd_qp]) * addr_t'(WQE_BYTES);

    // producer index per QP wraps at the queue depth
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int q = 0; q < MAX_QP; q++)
                sq_pi[q] <= '0;
        end
        else
        begin
            for (int q = 0; q < MAX_QP; q++)
            begin
                if (cmd_fire && (i_cmd_qp == QPID_WIDTH'(q)))
                begin
                    if (sq_pi[q] == PI_WIDTH'(SQ_DEPTH - 1))
                        sq_pi[q] <= '0;
                    else
                        sq_pi[q] <= sq_pi[q] + 1'b1;
                end
            end
        end
    end

    // AR -> R -> hand-off sequence
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_axi_arvalid <= 1'b0;
            o_axi_rready  <= 1'b0;
            o_rd_valid    <= 1'b0;
        end
        else
        begin
            if (cmd_fire)
                o_axi_arvalid <= 1'b1;
            else if (ar_fire)
                o_axi_arvalid <= 1'b0;

            if (ar_fire)
                o_axi_rready <= 1'b1;
            else if (r_fire)
                o_axi_rready <= 1'b0;

            if (r_fire)
                o_rd_valid <= 1'b1;
            else if (rd_fire)
                o_rd_valid <= 1'b0;
        end
    end

    // address and qp held from command to hand-off
    always_ff @(posedge clk)
    begin
        if (cmd_fire)
        begin
            o_axi_araddr <= wqe_addr;
            o_rd_qp      <= i_cmd_qp;
        end
        if (r_fire)
            o_rd_data <= i_axi_rdata;
    end

endmodule

`default_nettype wire

/* source/wqe_fetch_pkg.sv */
`default_nettype none

package wqe_fetch_pkg;

    // one WQE is exactly one AXI data beat
    localparam int WQE_WIDTH  = 512;
    localparam int WQE_BYTES  = WQE_WIDTH / 8;
    localparam int ADDR_WIDTH = 32;

    // QP number field stamped into the WQE
    localparam int QPID_LSB   = 328;
    localparam int QPID_WIDTH = 4;
    localparam int QPID_MSB   = QPID_LSB + QPID_WIDTH - 1;

    // zero bits above the stamped QP number
    localparam int PAD_WIDTH  = WQE_WIDTH - QPID_MSB - 1;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // raw memory beat, or the same word with the QP field stamped in
    typedef union packed {
        logic [WQE_WIDTH-1:0] raw;
        struct packed {
            logic [PAD_WIDTH-1:0]  pad;
            logic [QPID_WIDTH-1:0] qpn;
            logic [QPID_LSB-1:0]   body;
        } f;
    } wqe_u;

endpackage

`default_nettype wire

/* source/wqe_fetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module wqe_fetch_top
    import wqe_fetch_pkg::*;
#(
    parameter int MAX_QP   = 16,
    parameter int SQ_DEPTH = 4096
)(
    input  logic                  clk,
    input  logic                  rst_n,
    // arbiter and status
    output logic                  o_fetch_ready,
    input  logic                  i_arbit_val,
    input  logic [QPID_WIDTH-1:0] i_qp_idx,
    input  logic [MAX_QP-1:0]     i_active,
    input  logic [MAX_QP-1:0]     i_wqe_cache_alfull,
    input  addr_t                 i_sq_base,
    // AXI read master
    output addr_t                 o_axi_araddr,
    output logic                  o_axi_arvalid,
    input  logic                  i_axi_arready,
    input  logic [WQE_WIDTH-1:0]  i_axi_rdata,
    input  logic                  i_axi_rvalid,
    output logic                  o_axi_rready,
    // WQE cache
    output logic                  o_wqe_cache_wr,
    output logic [WQE_WIDTH-1:0]  o_wqe,
    input  logic [MAX_QP-1:0]     i_wqe_cache_full
);

    logic                  cmd_valid;
    logic                  cmd_ready;
    logic [QPID_WIDTH-1:0] cmd_qp;
    logic                  rd_valid;
    logic                  rd_ready;
    logic [QPID_WIDTH-1:0] rd_qp;
    logic [WQE_WIDTH-1:0]  rd_data;
    logic                  push_done;

    wqe_sched_decode #(
        .MAX_QP             (MAX_QP)
    ) u_decode (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_active           (i_active),
        .i_wqe_cache_alfull (i_wqe_cache_alfull),
        .i_arbit_val        (i_arbit_val),
        .i_qp_idx           (i_qp_idx),
        .i_cmd_ready        (cmd_ready),
        .i_push_done        (push_done),
        .o_fetch_ready      (o_fetch_ready),
        .o_cmd_valid        (cmd_valid),
        .o_cmd_qp           (cmd_qp)
    );

    sq_read_execute #(
        .MAX_QP             (MAX_QP),
        .SQ_DEPTH           (SQ_DEPTH)
    ) u_execute (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_sq_base          (i_sq_base),
        .i_cmd_valid        (cmd_valid),
        .i_cmd_qp           (cmd_qp),
        .o_cmd_ready        (cmd_ready),
        .o_axi_araddr       (o_axi_araddr),
        .o_axi_arvalid      (o_axi_arvalid),
        .i_axi_arready      (i_axi_arready),
        .i_axi_rdata        (i_axi_rdata),
        .i_axi_rvalid       (i_axi_rvalid),
        .o_axi_rready       (o_axi_rready),
        .o_rd_valid         (rd_valid),
        .o_rd_qp            (rd_qp),
        .o_rd_data          (rd_data),
        .i_rd_ready         (rd_ready)
    );

    wqe_push_result #(
        .MAX_QP             (MAX_QP)
    ) u_result (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_rd_valid         (rd_valid),
        .i_rd_qp            (rd_qp),
        .i_rd_data          (rd_data),
        .o_rd_ready         (rd_ready),
        .i_wqe_cache_full   (i_wqe_cache_full),
        .o_wqe_cache_wr     (o_wqe_cache_wr),
        .o_wqe              (o_wqe),
        .o_push_done        (push_done)
    );

endmodule

`default_nettype wire

/* source/wqe_push_result.sv */
`timescale 1ns/100ps
`default_nettype none

module wqe_push_result
    import wqe_fetch_pkg::*;
#(
    parameter int MAX_QP = 16
)(
    input  logic                  clk,
    input  logic                  rst_n,
    // beat from the read stage
    input  logic                  i_rd_valid,
    input  logic [QPID_WIDTH-1:0] i_rd_qp,
    input  logic [WQE_WIDTH-1:0]  i_rd_data,
    output logic                  o_rd_ready,
    // WQE cache
    input  logic [MAX_QP-1:0]     i_wqe_cache_full,
    output logic                  o_wqe_cache_wr,
    output logic [WQE_WIDTH-1:0]  o_wqe,
    output logic                  o_push_done
);

    wqe_u beat;
    wqe_u stamped;
    wqe_u wqe_q;
    logic rd_fire;

    // keep the descriptor body, overwrite the QP field, clear the top
    always_comb
    begin
        beat.raw         = i_rd_data;
        stamped.f.pad    = '0;
        stamped.f.qpn    = i_rd_qp;
        stamped.f.body   = beat.f.body;
    end

    // one WQE held at a time
    assign o_rd_ready = ~o_wqe_cache_wr;
    assign rd_fire    = i_rd_valid & o_rd_ready;

    // full is looked up by the QP stamped in the held WQE
    assign o_push_done = o_wqe_cache_wr & ~i_wqe_cache_full[wqe_q.f.qpn];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_wqe_cache_wr <= 1'b0;
        else if (rd_fire)
            o_wqe_cache_wr <= 1'b1;
        else if (o_push_done)
            o_wqe_cache_wr <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rd_fire)
            wqe_q <= stamped;
    end

    assign o_wqe = wqe_q.raw;

endmodule

`default_nettype wire

/* source/wqe_sched_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module wqe_sched_decode
    import wqe_fetch_pkg::*;
#(
    parameter int MAX_QP = 16
)(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [MAX_QP-1:0]     i_active,
    input  logic [MAX_QP-1:0]     i_wqe_cache_alfull,
    input  logic                  i_arbit_val,
    input  logic [QPID_WIDTH-1:0] i_qp_idx,
    input  logic                  i_cmd_ready,
    input  logic                  i_push_done,
    output logic                  o_fetch_ready,
    output logic                  o_cmd_valid,
    output logic [QPID_WIDTH-1:0] o_cmd_qp
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_ISSUE = 2'd1;
    localparam logic [1:0] S_WAIT  = 2'd2;

    logic [1:0]            state;
    logic [1:0]            state_nxt;
    logic [QPID_WIDTH-1:0] qp_q;
    logic                  grant;
    logic                  req_ok;

    // a grant only counts while we are asking for one
    assign grant  = i_arbit_val & o_fetch_ready;
    // something to fetch and somewhere to put it
    assign req_ok = (|i_active) & ~(&i_wqe_cache_alfull);

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:
            begin
                if (grant)
                    state_nxt = S_ISSUE;
            end
            S_ISSUE:
            begin
                if (i_cmd_ready)
                    state_nxt = S_WAIT;
            end
            S_WAIT:
            begin
                if (i_push_done)
                    state_nxt = S_IDLE;
            end
            default:
            begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= S_IDLE;
            o_fetch_ready <= 1'b0;
        end
        else
        begin
            state         <= state_nxt;
            // request again right after the previous WQE has been pushed
            o_fetch_ready <= req_ok & (((state == S_IDLE) & ~grant) |
                                       ((state == S_WAIT) & i_push_done));
        end
    end

    // granted QP held for the whole fetch
    always_ff @(posedge clk)
    begin
        if (grant)
            qp_q <= i_qp_idx;
    end

    assign o_cmd_valid = (state == S_ISSUE);
    assign o_cmd_qp    = qp_q;

endmodule

`default_nettype wire

/* test/wqe_fetch_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module wqe_fetch_checker
    import wqe_fetch_pkg::*;
#(
    parameter int MAX_QP = 16
)(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_arbit_val,
    input  logic                 i_fetch_ready,
    input  addr_t                i_araddr,
    input  logic                 i_arvalid,
    input  logic                 i_arready,
    input  logic                 i_cache_wr,
    input  logic [WQE_WIDTH-1:0] i_wqe,
    input  logic [MAX_QP-1:0]    i_cache_full
);

    logic [QPID_WIDTH-1:0] stamped_qp;
    logic                  grant;
    logic                  push;
    logic                  in_flight;

    assign stamped_qp = i_wqe[QPID_MSB:QPID_LSB];
    assign grant      = i_arbit_val & i_fetch_ready;
    assign push       = i_cache_wr & ~i_cache_full[stamped_qp];

    // set by a grant, cleared when the cache takes the WQE
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            in_flight <= 1'b0;
        else if (grant)
            in_flight <= 1'b1;
        else if (push)
            in_flight <= 1'b0;
    end

    ar_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
        else $error("AXI read address or valid changed before arready");

    wr_held_while_full: assert property (@(posedge clk) disable iff (!rst_n)
        i_cache_wr && i_cache_full[stamped_qp] |=> i_cache_wr && $stable(i_wqe))
        else $error("WQE cache write dropped or changed while full");

    no_request_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight |-> !i_fetch_ready)
        else $error("fetch request raised while a WQE is in flight");

endmodule

bind wqe_fetch_top wqe_fetch_checker #(
    .MAX_QP        (MAX_QP)
) u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_arbit_val   (i_arbit_val),
    .i_fetch_ready (o_fetch_ready),
    .i_araddr      (o_axi_araddr),
    .i_arvalid     (o_axi_arvalid),
    .i_arready     (i_axi_arready),
    .i_cache_wr    (o_wqe_cache_wr),
    .i_wqe         (o_wqe),
    .i_cache_full  (i_wqe_cache_full)
);

`default_nettype wire

/* test/wqe_fetch_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module wqe_fetch_tb
    import wqe_fetch_pkg::*;
();

    localparam int    MAX_QP      = 16;
    localparam int    SQ_DEPTH    = 4;
    localparam int    MAX_WAIT    = 64;
    localparam addr_t SQ_BASE     = 32'h4000_0000;
    localparam int    SIG_FETCH   = 0;
    localparam int    SIG_ARVALID = 1;
    localparam int    SIG_WR      = 2;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  fetch_ready;
    logic                  arbit_val;
    logic [QPID_WIDTH-1:0] qp_idx;
    logic [MAX_QP-1:0]     active;
    logic [MAX_QP-1:0]     alfull;
    logic [MAX_QP-1:0]     cache_full;
    addr_t                 araddr;
    logic                  arvalid;
    logic                  arready;
    logic [WQE_WIDTH-1:0]  rdata;
    logic                  rvalid;
    logic                  rready;
    logic                  cache_wr;
    logic [WQE_WIDTH-1:0]  wqe_data;

    int checks;
    int errors;
    int ref_pi [MAX_QP];

    wqe_fetch_top #(
        .MAX_QP             (MAX_QP),
        .SQ_DEPTH           (SQ_DEPTH)
    ) uut (
        .clk                (clk),
        .rst_n              (rst_n),
        .o_fetch_ready      (fetch_ready),
        .i_arbit_val        (arbit_val),
        .i_qp_idx           (qp_idx),
        .i_active           (active),
        .i_wqe_cache_alfull (alfull),
        .i_sq_base          (SQ_BASE),
        .o_axi_araddr       (araddr),
        .o_axi_arvalid      (arvalid),
        .i_axi_arready      (arready),
        .i_axi_rdata        (rdata),
        .i_axi_rvalid       (rvalid),
        .o_axi_rready       (rready),
        .o_wqe_cache_wr     (cache_wr),
        .o_wqe              (wqe_data),
        .i_wqe_cache_full   (cache_full)
    );

    always #2 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory content depends on the line seed and the full byte address
    function automatic logic [WQE_WIDTH-1:0] memory_beat(input logic [31:0] seed,
                                                         input addr_t addr);
        logic [31:0]          st;
        logic [WQE_WIDTH-1:0] beat;
        st = seed ^ 32'h8e24 ^ addr;
        for (int w = 0; w < WQE_WIDTH / 32; w++)
        begin
            st = lcg_next(st);
            beat[w*32 +: 32] = st;
        end
        return beat;
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SIG_FETCH:   return fetch_ready;
            SIG_ARVALID: return arvalid;
            SIG_WR:      return cache_wr;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic wait_high(input int sel, input string what, output bit ok);
        int n;
        n = 0;
        while (!probe(sel) && n < MAX_WAIT)
        begin
            next_cycle();
            n++;
        end
        ok = probe(sel);
        if (!ok)
        begin
            $display("timeout after %0d cycles waiting for %s", MAX_WAIT, what);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_wqe(input string name, input wqe_u got, input wqe_u exp);
        checks++;
        if (got.raw !== exp.raw)
        begin
            $display("mismatch %s: got %h, expected %h", name, got.raw, exp.raw);
            errors++;
        end
    endtask

    task automatic report_vector(input int idx, input int qp, input int err_start);
        if (errors == err_start)
            $display("vector %0d qp %0d: ok", idx, qp);
        else
            $display("vector %0d qp %0d: %0d errors", idx, qp, errors - err_start);
    endtask

    task automatic run_vector(input int idx, input int qp, input logic [31:0] act,
                              input logic [31:0] alf, input int ar_dly, input int r_dly,
                              input int stall, input logic [31:0] seed, output bit ok);
        int    err_start;
        int    n;
        int    pushes;
        addr_t exp_addr;
        addr_t ar_addr;
        wqe_u  exp_wqe;
        wqe_u  held;
        err_start = errors;
        ok        = 1'b1;
        active    = act[MAX_QP-1:0];
        alfull    = alf[MAX_QP-1:0];
        // nothing to fetch or nowhere to put it, so no request
        if (active == '0 || &alfull)
        begin
            next_cycle();
            next_cycle();
            for (int i = 0; i < 8; i++)
            begin
                check_bit("o_fetch_ready", fetch_ready, 1'b0);
                next_cycle();
            end
            report_vector(idx, qp, err_start);
            return;
        end
        // a neighbour's full bit must not stall this QP
        cache_full = '0;
        cache_full[(qp + 1) % MAX_QP] = 1'b1;
        cache_full[qp] = (stall > 0);
        wait_high(SIG_FETCH, "o_fetch_ready", ok);
        if (ok)
        begin
            arbit_val = 1'b1;
            qp_idx    = QPID_WIDTH'(qp);
            next_cycle();
            arbit_val = 1'b0;
            check_bit("o_fetch_ready", fetch_ready, 1'b0);
            exp_addr  = SQ_BASE + addr_t'(qp * SQ_DEPTH * 64) + addr_t'(ref_pi[qp] * 64);
            ref_pi[qp] = (ref_pi[qp] + 1) % SQ_DEPTH;
            wait_high(SIG_ARVALID, "o_axi_arvalid", ok);
        end
        if (ok)
        begin
            ar_addr = araddr;
            check_addr("o_axi_araddr", ar_addr, exp_addr);
            check_bit("o_axi_rready", rready, 1'b0);
            repeat (ar_dly) next_cycle();
            arready = 1'b1;
            next_cycle();
            arready = 1'b0;
            check_bit("o_axi_arvalid", arvalid, 1'b0);
            check_bit("o_axi_rready", rready, 1'b1);
            repeat (r_dly) next_cycle();
            rdata  = memory_beat(seed, ar_addr);
            rvalid = 1'b1;
            n      = 0;
            ok     = 1'b0;
            while (!ok && n < MAX_WAIT)
            begin
                ok = rready;
                next_cycle();
                n++;
            end
            rvalid = 1'b0;
            if (!ok)
            begin
                $display("timeout after %0d cycles waiting for o_axi_rready", MAX_WAIT);
                errors++;
            end
        end
        if (ok)
            wait_high(SIG_WR, "o_wqe_cache_wr", ok);
        if (ok)
        begin
            exp_wqe.raw   = rdata;
            exp_wqe.f.pad = '0;
            exp_wqe.f.qpn = QPID_WIDTH'(qp);
            check_wqe("o_wqe", wqe_data, exp_wqe);
            held = wqe_data;
            for (int i = 0; i < stall; i++)
            begin
                next_cycle();
                check_bit("o_wqe_cache_wr", cache_wr, 1'b1);
                check_wqe("o_wqe", wqe_data, held);
            end
            cache_full[qp] = 1'b0;
            pushes = 0;
            for (int i = 0; i < 3; i++)
            begin
                if (cache_wr)
                    pushes++;
                next_cycle();
            end
            checks++;
            if (pushes != 1)
            begin
                $display("WQE cache push seen %0d times instead of once", pushes);
                errors++;
            end
        end
        report_vector(idx, qp, err_start);
    endtask

    initial
    begin
        int          fd;
        int          nvec;
        int          qp;
        int          ar_dly;
        int          r_dly;
        int          stall;
        logic [31:0] act;
        logic [31:0] alf;
        logic [31:0] seed;
        string       line;
        bit          ok;
        rst_n      = 1'b0;
        arbit_val  = 1'b0;
        qp_idx     = '0;
        active     = '0;
        alfull     = '0;
        cache_full = '0;
        arready    = 1'b0;
        rdata      = '0;
        rvalid     = 1'b0;
        checks     = 0;
        errors     = 0;
        nvec       = 0;
        for (int q = 0; q < MAX_QP; q++)
            ref_pi[q] = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bit("o_fetch_ready", fetch_ready, 1'b0);
        check_bit("o_axi_arvalid", arvalid, 1'b0);
        check_bit("o_axi_rready", rready, 1'b0);
        check_bit("o_wqe_cache_wr", cache_wr, 1'b0);
        fd = $fopen("test/wqe_fetch_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open test/wqe_fetch_vectors.txt");
            errors++;
        end
        else
        begin
            ok = 1'b1;
            while (ok && !$feof(fd))
            begin
                if ($fgets(line, fd) > 0 && $sscanf(line, "%h %h %h %h %h %h %h",
                        qp, act, alf, ar_dly, r_dly, stall, seed) == 7)
                begin
                    run_vector(nvec, qp, act, alf, ar_dly, r_dly, stall, seed, ok);
                    nvec++;
                end
            end
            $fclose(fd);
            if (nvec == 0)
            begin
                $display("no vectors were read from the vector file");
                errors++;
            end
        end
        $display("vectors %0d, checks %0d, errors %0d", nvec, checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/wqe_fetch_vectors.txt */
# columns, all hex: qp active_mask alfull_mask arready_delay rvalid_delay full_stall seed
# a zero active mask or an all-ones alfull mask expects no fetch request
3 0008 0000 0 0 0 1001
3 0008 0000 2 1 0 1002
5 0028 0000 1 3 2 1003
3 0028 0020 0 2 1 1004
0 0000 0000 0 0 0 0000
5 0028 0000 3 0 0 1005
3 000b 0001 1 1 4 1006
3 ffff ffff 0 0 0 0000
3 000b 0000 0 0 0 1007
f 8000 0000 2 2 1 1008
0 0001 fffe 0 1 3 100a
3 8008 0000 0 0 0 1009
5 0020 0000 4 4 0 100b
5 0020 0000 0 0 5 100c
5 0020 0000 1 0 0 100d
7 0080 ff7f 0 2 2 100e

/* vlog.f */
source/wqe_fetch_pkg.sv
source/wqe_sched_decode.sv
source/sq_read_execute.sv
source/wqe_push_result.sv
source/wqe_fetch_top.sv
test/wqe_fetch_checker.sv
test/wqe_fetch_tb.sv
